// File: list.f
+incdir+testbench
logic/mfe_pkg.sv
logic/mfe_ctrl.sv
logic/window_fetch.sv
logic/median9.sv
logic/mfe_top.sv
testbench/mfe_chk.sv
testbench/tb_mfe.sv

// File: Bender.yml
package:
  name: mfe

sources:
  - files:
      - logic/mfe_pkg.sv
      - logic/mfe_ctrl.sv
      - logic/window_fetch.sv
      - logic/median9.sv
      - logic/mfe_top.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/mfe_chk.sv
      - testbench/tb_mfe.sv

// File: testbench/mfe_ref_model.svh
`ifndef MFE_REF_MODEL_SVH
`define MFE_REF_MODEL_SVH

logic [31:0] rng_state;                 // LCG state
pix_t        image [0:pix_count-1];     // image ROM contents

function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
endfunction

// seeded random image
task automatic fill_random();
    rng_state = lcg_seed;
    for (int a = 0; a < pix_count; a++) begin
        rng_state = lcg_next(rng_state);
        image[a]  = rng_state[31:24];   // top bits, low ones cycle fast
    end
endtask

task automatic fill_flat(input pix_t level);
    for (int a = 0; a < pix_count; a++)
        image[a] = level;
endtask

// anything off the image reads as zero
function automatic pix_t tap_value(input int row, input int col);
    if ((row < 0) || (row >= img_dim) || (col < 0) || (col >= img_dim))
        return '0;
    return image[row * img_dim + col];
endfunction

// plain insertion sort of the nine taps
function automatic pix_t soft_median(input int row, input int col);
    pix_t v [0:win_taps-1];
    pix_t t;
    int   j;
    for (int k = 0; k < win_taps; k++)
        v[k] = tap_value(row + k / 3 - 1, col + k % 3 - 1);   // row-major 3x3
    for (int i = 1; i < win_taps; i++) begin
        t = v[i];
        j = i - 1;
        while ((j >= 0) && (v[j] > t)) begin
            v[j + 1] = v[j];
            j--;
        end
        v[j + 1] = t;
    end
    return v[win_taps / 2];   // middle of nine
endfunction

`endif

// File: testbench/tb_mfe.sv
`timescale 1ns/1ps

module tb_mfe;

    import mfe_pkg::*;

    localparam int          pix_count  = img_dim * img_dim;
    localparam int          clk_period = 40;
    localparam int          drive_dly  = 2;     // input skew after posedge
    localparam int          pix_cycles = 13;    // write spacing
    localparam logic [31:0] lcg_seed   = 32'h23ea_d7f3;
    // two frames plus ten percent
    localparam longint      wd_ns = longint'(2 * pix_count * pix_cycles * clk_period) * 11 / 10;

    logic    clk;
    logic    reset;
    logic    ready;
    logic    busy;
    addr_t   iaddr;
    pix_t    idata;
    wr_req_t wr;
    addr_t   rd_addr;                      // ROM address held over the edge
    pix_t    expect_mem [0:pix_count-1];
    pix_t    result_mem [0:pix_count-1];
    int      wr_count   [0:pix_count-1];   // writes seen per address

    `include "mfe_ref_model.svh"

    mfe_top mfe_top_i (
        .clk   (clk),
        .reset (reset),
        .ready (ready),
        .busy  (busy),
        .iaddr (iaddr),
        .idata (idata),
        .wr    (wr)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // image ROM returns data one edge after the address
    always begin
        @(negedge clk);
        rd_addr = iaddr;
        @(posedge clk);
        #(drive_dly) idata = image[rd_addr];
    end

    // result memory
    always @(negedge clk) begin
        if (wr.en === 1'b1) begin
            result_mem[wr.addr] = wr.data;
            wr_count[wr.addr]   = wr_count[wr.addr] + 1;
        end
    end

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] want);
        if (got !== want)
            stop_run($sformatf("MISMATCH %s got 0x%0h expected 0x%0h", name, got, want));
    endtask

    task automatic step(input int n);
        repeat (n) @(posedge clk);
        #(drive_dly);
    endtask

    // a corner of a flat image has five padded taps so zero wins
    function automatic pix_t flat_expect(input int row, input int col, input pix_t level);
        logic row_edge;
        logic col_edge;
        row_edge = (row == 0) || (row == img_dim - 1);
        col_edge = (col == 0) || (col == img_dim - 1);
        return (row_edge && col_edge) ? '0 : level;
    endfunction

    task automatic run_frame();
        int gap;
        for (int a = 0; a < pix_count; a++)
            wr_count[a] = 0;
        step(2);
        ready = 1'b1;                            // one-cycle start pulse
        step(1);
        ready = 1'b0;
        @(negedge clk);
        check_val("busy", busy, 1'b1);
        gap = 0;
        for (int n = 0; n < pix_count; n++) begin
            do begin
                @(negedge clk);
                gap++;
            end while (wr.en !== 1'b1);
            check_val("wr.addr", wr.addr, n);    // strict raster order
            check_val("busy", busy, 1'b1);
            if (n > 0)
                check_val("write spacing", gap, pix_cycles);
            gap = 0;
        end
        @(negedge clk);
        check_val("busy", busy, 1'b0);           // falls with the last write
        check_val("wr.en", wr.en, 1'b0);
        for (int a = 0; a < pix_count; a++) begin
            check_val($sformatf("wr_count[%0d]", a), wr_count[a], 1);
            check_val($sformatf("result_mem[%0d]", a), result_mem[a], expect_mem[a]);
        end
    endtask

    initial begin
        reset = 1'b1;
        ready = 1'b0;
        idata = '0;
        fill_random();
        for (int a = 0; a < pix_count; a++)
            expect_mem[a] = soft_median(a / img_dim, a % img_dim);
        step(3);
        reset = 1'b0;
        check_val("iaddr", iaddr, 0);
        repeat (5) begin
            @(negedge clk);
            check_val("busy", busy, 1'b0);       // idle until ready
            check_val("wr.en", wr.en, 1'b0);
            check_val("iaddr", iaddr, 0);
        end
        run_frame();

        // restart on a flat bright image
        fill_flat(8'hff);
        for (int a = 0; a < pix_count; a++)
            expect_mem[a] = flat_expect(a / img_dim, a % img_dim, 8'hff);
        run_frame();

        $display("sim passed");
        $finish;
    end

    // stop at the first failed checker assertion
    initial begin
        wait (mfe_top_i.mfe_chk_i.fail_count != 0);
        stop_run("an assertion of the bound checker on mfe_top failed");
    end

    // watchdog
    initial begin
        #(wd_ns);
        stop_run("timeout, the two frames did not complete in the expected time");
    end

endmodule

// File: testbench/mfe_chk.sv
`timescale 1ns/1ps

module mfe_chk (
    input logic             clk,
    input logic             reset,
    input logic             ready,
    input logic             busy,
    input mfe_pkg::addr_t   iaddr,
    input mfe_pkg::wr_req_t wr
);

    import mfe_pkg::*;

    int fail_count = 0;    // failed assertions so far

    wr_in_frame: assert property (@(posedge clk) disable iff (reset) wr.en |-> busy)
        else begin
            $error("result write outside a frame");
            fail_count++;
        end

    wr_one_cycle: assert property (@(posedge clk) disable iff (reset) wr.en |=> !wr.en)
        else begin
            $error("result write held for two cycles");
            fail_count++;
        end

    // busy low means the controller sits in IDLE
    busy_start: assert property (@(posedge clk) disable iff (reset) $rose(busy) |-> $past(ready))
        else begin
            $error("busy rose without a start request");
            fail_count++;
        end

    // iaddr still holds the last tap during the write
    // lower-right neighbour inside the image, centre when padded, never a wrapped address
    iaddr_range: assert property (@(posedge clk) disable iff (reset)
                                  wr.en |-> (iaddr == wr.addr) ||
                                            (int'(iaddr) == int'(wr.addr) + img_dim + 1))
        else begin
            $error("image address outside the window of the written pixel");
            fail_count++;
        end

endmodule

bind mfe_top mfe_chk mfe_chk_i (
    .clk   (clk),
    .reset (reset),
    .ready (ready),
    .busy  (busy),
    .iaddr (iaddr),
    .wr    (wr)
);

// File: logic/mfe_top.sv
`timescale 1ns/1ps

module mfe_top (
    input  logic             clk,
    input  logic             reset,
    input  logic             ready,   // host start pulse
    output logic             busy,    // high for the whole frame
    output mfe_pkg::addr_t   iaddr,   // to the image ROM
    input  mfe_pkg::pix_t    idata,   // ROM data one cycle after iaddr
    output mfe_pkg::wr_req_t wr       // result memory write, always accepted
);

    import mfe_pkg::*;

    logic       fetch_start;   // ctrl asks for a new window
    pixel_pos_t pos;           // centre of that window
    window_t    window;        // nine padded taps
    logic       win_valid;
    pix_t       median;
    logic       med_valid;

    // frame sequencing and result write
    mfe_ctrl mfe_ctrl_i (
        .clk         (clk),
        .reset       (reset),
        .ready       (ready),
        .busy        (busy),
        .fetch_start (fetch_start),
        .pos         (pos),
        .med_valid   (med_valid),
        .median      (median),
        .wr          (wr)
    );

    // tap addressing and border padding
    window_fetch window_fetch_i (
        .clk         (clk),
        .reset       (reset),
        .fetch_start (fetch_start),
        .pos         (pos),
        .iaddr       (iaddr),
        .idata       (idata),
        .window      (window),
        .win_valid   (win_valid)
    );

    // two-stage sort network
    median9 median9_i (
        .clk         (clk),
        .reset       (reset),
        .window      (window),
        .win_valid   (win_valid),
        .median      (median),
        .med_valid   (med_valid)
    );

endmodule

// File: logic/median9.sv
`timescale 1ns/1ps

module median9 (
    input  logic             clk,
    input  logic             reset,
    input  mfe_pkg::window_t window,
    input  logic             win_valid,
    output mfe_pkg::pix_t    median,
    output logic             med_valid   // two cycles after win_valid
);

    import mfe_pkg::*;

    pix_t tap [0:2][0:2];      // [row][col] view of the window
    pix_t row_max [0:2];
    pix_t row_med [0:2];
    pix_t row_min [0:2];
    logic s1_valid;
    pix_t hi_min;              // largest of the row minima
    pix_t mid_med;             // middle of the row medians
    pix_t lo_max;              // smallest of the row maxima

    assign tap[0][0] = window.top_l;
    assign tap[0][1] = window.top_c;
    assign tap[0][2] = window.top_r;
    assign tap[1][0] = window.mid_l;
    assign tap[1][1] = window.mid_c;
    assign tap[1][2] = window.mid_r;
    assign tap[2][0] = window.bot_l;
    assign tap[2][1] = window.bot_c;
    assign tap[2][2] = window.bot_r;

    // stage one sorts each row
    always_ff @(posedge clk) begin
        if (win_valid) begin
            for (int r = 0; r < 3; r++) begin
                row_max[r] <= max3(tap[r][0], tap[r][1], tap[r][2]);
                row_med[r] <= med3(tap[r][0], tap[r][1], tap[r][2]);
                row_min[r] <= min3(tap[r][0], tap[r][1], tap[r][2]);
            end
        end
    end

    // stage two crosses the sorted rows
    // median of nine lies between these three candidates
    always_comb begin
        hi_min  = max3(row_min[0], row_min[1], row_min[2]);
        mid_med = med3(row_med[0], row_med[1], row_med[2]);
        lo_max  = min3(row_max[0], row_max[1], row_max[2]);
    end

    always_ff @(posedge clk) begin
        if (s1_valid)
            median <= med3(hi_min, mid_med, lo_max);
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            s1_valid  <= 1'b0;
            med_valid <= 1'b0;
        end else begin
            s1_valid  <= win_valid;
            med_valid <= s1_valid;   // follows median register
        end
    end

endmodule

// File: logic/window_fetch.sv
`timescale 1ns/1ps

module window_fetch (
    input  logic                clk,
    input  logic                reset,
    input  logic                fetch_start,  // begin a new window around pos
    input  mfe_pkg::pixel_pos_t pos,
    output mfe_pkg::addr_t      iaddr,        // image ROM address
    input  mfe_pkg::pix_t       idata,        // ROM data, one cycle behind iaddr
    output mfe_pkg::window_t    window,
    output logic                win_valid
);

    import mfe_pkg::*;

    // one bit wider than a coordinate so that -1 and img_dim both fall out of range
    typedef logic [$bits(coord_t):0] ext_t;

    logic [1:0] roff;        // 0,1,2 stand for row offset -1,0,+1
    logic [1:0] coff;        // same for columns
    logic [1:0] roff_nxt;
    logic [1:0] coff_nxt;
    logic       issuing;     // a tap address sits on iaddr
    logic       last_tap;
    ext_t       nb_row;
    ext_t       nb_col;
    pixel_pos_t nb_pos;
    logic       nb_in;       // neighbour inside the image
    addr_t      addr_nxt;
    logic       in_q;        // range flag of the address on iaddr
    logic       in_d;        // same flag lined up with idata
    logic       cap_act;     // idata holds a tap this cycle
    logic [3:0] cap_idx;     // which tap idata belongs to
    pix_t       tap_pix;
    pix_t       cap_q [0:win_taps-2];

    assign last_tap = (roff == 2'd2) && (coff == 2'd2);

    // walk the offsets row-major
    always_comb begin
        if (fetch_start) begin
            roff_nxt = 2'd0;
            coff_nxt = 2'd0;
        end else if (coff == 2'd2) begin
            roff_nxt = roff + 2'd1;
            coff_nxt = 2'd0;
        end else begin
            roff_nxt = roff;
            coff_nxt = coff + 2'd1;
        end
    end

    // neighbour position and the range decision
    always_comb begin
        nb_row     = ext_t'(pos.row) + ext_t'(roff_nxt) - ext_t'(1);
        nb_col     = ext_t'(pos.col) + ext_t'(coff_nxt) - ext_t'(1);
        nb_in      = (nb_row < img_dim) && (nb_col < img_dim);
        nb_pos.row = coord_t'(nb_row);
        nb_pos.col = coord_t'(nb_col);
        // padded taps re-read the centre, value thrown away later
        addr_nxt   = nb_in ? addr_t'(nb_pos) : addr_t'(pos);
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            issuing <= 1'b0;
            roff    <= 2'd0;
            coff    <= 2'd0;
            iaddr   <= '0;
            in_q    <= 1'b0;
            in_d    <= 1'b0;
            cap_act <= 1'b0;
            cap_idx <= 4'd0;
        end else begin
            if (fetch_start || (issuing && !last_tap)) begin
                issuing <= 1'b1;
                roff    <= roff_nxt;
                coff    <= coff_nxt;
                iaddr   <= addr_nxt;
                in_q    <= nb_in;
            end else begin
                issuing <= 1'b0;            // iaddr keeps its last value
            end
            in_d    <= in_q;
            cap_act <= issuing;
            cap_idx <= {2'b00, roff} * 4'd3 + {2'b00, coff};
        end
    end

    assign tap_pix = in_d ? idata : '0;    // zero padding outside the image

    // taps 0..7 stored, tap 8 goes straight through
    always_ff @(posedge clk) begin
        if (cap_act && (cap_idx < 4'(win_taps - 1)))
            cap_q[cap_idx[2:0]] <= tap_pix;
    end

    assign win_valid = cap_act && (cap_idx == 4'(win_taps - 1));

    assign window = '{top_l: cap_q[0], top_c: cap_q[1], top_r: cap_q[2],
                      mid_l: cap_q[3], mid_c: cap_q[4], mid_r: cap_q[5],
                      bot_l: cap_q[6], bot_c: cap_q[7], bot_r: tap_pix};

endmodule

// File: logic/mfe_ctrl.sv
`timescale 1ns/1ps

module mfe_ctrl (
    input  logic                clk,
    input  logic                reset,
    input  logic                ready,        // host start pulse
    output logic                busy,
    output logic                fetch_start,  // one cycle, window_fetch samples pos
    output mfe_pkg::pixel_pos_t pos,          // centre pixel of the window in flight
    input  logic                med_valid,
    input  mfe_pkg::pix_t       median,
    output mfe_pkg::wr_req_t    wr
);

    import mfe_pkg::*;

    mfe_state_t state;
    mfe_state_t state_nxt;
    pixel_pos_t pos_nxt;     // raster successor of pos
    logic       last_pix;    // pos is the bottom-right pixel
    logic       last_q;      // the write in progress closes the frame
    logic       take_med;    // median arrives for the current pixel
    logic       wr_en_q;
    addr_t      wr_addr_q;
    pix_t       wr_data_q;

    assign last_pix = (pos.row == coord_t'(img_dim - 1)) &&
                      (pos.col == coord_t'(img_dim - 1));

    assign take_med = (state == FILTER) && med_valid;

    // column first, then wrap into the next row
    always_comb begin
        pos_nxt = pos;
        if (pos.col == coord_t'(img_dim - 1)) begin
            pos_nxt.col = '0;
            pos_nxt.row = pos.row + 1'b1;   // rolls over to 0 after the last row
        end else begin
            pos_nxt.col = pos.col + 1'b1;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (ready)
                    state_nxt = FETCH;
            end
            FETCH:   state_nxt = FILTER;     // first pixel of the frame only
            FILTER: begin
                if (med_valid)
                    state_nxt = WRITE;
            end
            WRITE:   state_nxt = last_q ? IDLE : FILTER;
            default: state_nxt = IDLE;
        endcase
    end

    // next pixel's fetch overlaps the write cycle
    // keeps the write spacing at 13 cycles
    assign fetch_start = (state == FETCH) || ((state == WRITE) && !last_q);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state   <= IDLE;
            busy    <= 1'b0;
            pos     <= '0;
            last_q  <= 1'b0;
            wr_en_q <= 1'b0;
        end else begin
            state   <= state_nxt;
            wr_en_q <= take_med;            // single cycle pulse
            if ((state == IDLE) && ready)
                busy <= 1'b1;               // ready ignored outside IDLE
            if (take_med) begin
                last_q <= last_pix;
                pos    <= pos_nxt;          // new centre visible with fetch_start
            end
            if ((state == WRITE) && last_q)
                busy <= 1'b0;               // falls with wr.en
        end
    end

    // address from the pixel being finished, before pos moves on
    always_ff @(posedge clk) begin
        if (take_med) begin
            wr_addr_q <= addr_t'(pos);
            wr_data_q <= median;
        end
    end

    assign wr = '{en: wr_en_q, addr: wr_addr_q, data: wr_data_q};

endmodule

// File: logic/mfe_pkg.sv
package mfe_pkg;

    localparam int img_dim  = 128;  // pixels per row and per column
    localparam int addr_w   = 14;   // img_dim squared addresses
    localparam int pix_w    = 8;    // greyscale depth
    localparam int win_taps = 9;    // 3x3 neighbourhood

    typedef logic [pix_w-1:0]           pix_t;
    typedef logic [addr_w-1:0]          addr_t;
    typedef logic [$clog2(img_dim)-1:0] coord_t;

    // centre pixel of a window
    // row sits above col so a cast to addr_t gives row*img_dim + col
    typedef struct packed {
        coord_t row;
        coord_t col;
    } pixel_pos_t;

    // row-major taps, mid_c is the centre
    typedef struct packed {
        pix_t top_l;
        pix_t top_c;
        pix_t top_r;
        pix_t mid_l;
        pix_t mid_c;
        pix_t mid_r;
        pix_t bot_l;
        pix_t bot_c;
        pix_t bot_r;
    } window_t;

    // result memory write port
    typedef struct packed {
        logic  en;
        addr_t addr;
        pix_t  data;
    } wr_req_t;

    typedef enum logic [1:0] {IDLE, FETCH, FILTER, WRITE} mfe_state_t;

    function automatic pix_t max3(pix_t a, pix_t b, pix_t c);
        pix_t ab;
        ab = (a > b) ? a : b;
        return (ab > c) ? ab : c;
    endfunction

    function automatic pix_t min3(pix_t a, pix_t b, pix_t c);
        pix_t ab;
        ab = (a < b) ? a : b;
        return (ab < c) ? ab : c;
    endfunction

    function automatic pix_t med3(pix_t a, pix_t b, pix_t c);
        pix_t lo;
        pix_t hi;
        lo = (a < b) ? a : b;   // order the first pair
        hi = (a < b) ? b : a;
        if (c <= lo)
            return lo;          // c smallest
        if (c >= hi)
            return hi;          // c largest
        return c;
    endfunction

endpackage
